// ==== verilog/tcdm_pkg.sv ====
// -------------------------------------------------
// shared widths, payload structs and enums for the
// TCDM front end. modules refer to it by scoped names.
// -------------------------------------------------
`default_nettype none

package tcdm_pkg;

  // -------------------------------------------------
  // widths
  // -------------------------------------------------
  localparam int unsigned DW     = 32;       // data word.
  localparam int unsigned BEW    = DW / 8;   // one enable per byte.
  localparam int unsigned AW     = 16;       // word address inside a bank.
  localparam int unsigned UW     = 4;        // user tag.
  localparam int unsigned CFG_DW = 32;       // config port data.

  // -------------------------------------------------
  // request and response payload
  // -------------------------------------------------
  typedef struct packed {
    logic [AW-1:0]  add;   // word address.
    logic           wen;   // 1 = read, 0 = write.
    logic [BEW-1:0] be;    // byte enables for writes.
    logic [DW-1:0]  data;  // write data.
    logic [UW-1:0]  user;  // tag, echoed back.
  } tcdm_req_t;

  typedef enum logic {
    OPC_OK  = 1'b0,  // access in range.
    OPC_ERR = 1'b1   // address past bank depth.
  } rsp_opc_e;

  typedef struct packed {
    logic [DW-1:0] r_data;  // read data, zero on writes.
    rsp_opc_e      r_opc;   // status.
    logic [UW-1:0] r_user;  // tag of the request.
  } tcdm_rsp_t;

  // -------------------------------------------------
  // configuration register map
  // -------------------------------------------------
  typedef enum logic [7:0] {
    CFG_CTRL     = 8'd0,  // write-only, bit 0 clears.
    CFG_MASK     = 8'd1,  // channel enables.
    CFG_CNT_BASE = 8'd2   // grant counter of channel 0, then 1, 2...
  } cfg_addr_e;

endpackage

`default_nettype wire

// ==== verilog/tcdm_bank.sv ====
// -------------------------------------------------
// single-port word memory behind one mux port. grants
// at once, answers on the following cycle.
// -------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tcdm_bank #(
  parameter int unsigned BANK_WORDS = 256
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req,
  input  tcdm_pkg::tcdm_req_t req_data,
  output logic                gnt,
  output logic                rsp_valid,
  output tcdm_pkg::tcdm_rsp_t rsp
);

  localparam int unsigned IW = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

  logic [tcdm_pkg::DW-1:0] mem_q [BANK_WORDS];  // word storage.
  logic [IW-1:0]           idx;                 // word index.
  logic                    in_range;            // address below depth.
  logic                    rsp_valid_q;
  tcdm_pkg::tcdm_rsp_t     rsp_q;

  assign idx      = req_data.add[IW-1:0];
  assign in_range = 32'(req_data.add) < BANK_WORDS;
  assign gnt      = req;  // never stalls.

  // -------------------------------------------------
  // byte-enabled write
  // -------------------------------------------------
  always_ff @(posedge clk_i) begin : write_port
    if (req && !req_data.wen && in_range) begin
      for (int b = 0; b < tcdm_pkg::BEW; b++) begin
        if (req_data.be[b]) begin
          mem_q[idx][8*b +: 8] <= req_data.data[8*b +: 8];  // merge byte.
        end
      end
    end
  end

  // -------------------------------------------------
  // registered response
  // -------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : valid_reg
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req;  // one pulse per accepted request.
    end
  end

  always_ff @(posedge clk_i) begin : rsp_reg
    if (req) begin
      rsp_q.r_user <= req_data.user;  // echo tag.
      if (!in_range) begin
        rsp_q.r_opc  <= tcdm_pkg::OPC_ERR;  // dropped, zero data.
        rsp_q.r_data <= '0;
      end else begin
        rsp_q.r_opc  <= tcdm_pkg::OPC_OK;
        rsp_q.r_data <= req_data.wen ? mem_q[idx] : '0;  // writes return zero.
      end
    end
  end

  assign rsp_valid = rsp_valid_q;
  assign rsp       = rsp_q;

endmodule

`default_nettype wire

// ==== verilog/tcdm_mux_ctrl.sv ====
// -------------------------------------------------
// config block beside the mux: enable mask, clear
// pulse and saturating grant counters per channel.
// -------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tcdm_mux_ctrl #(
  parameter int unsigned NB_IN_CHAN = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        cfg_we,
  input  tcdm_pkg::cfg_addr_e         cfg_addr,
  input  logic [tcdm_pkg::CFG_DW-1:0] cfg_wdata,
  output logic [tcdm_pkg::CFG_DW-1:0] cfg_rdata,
  input  logic [NB_IN_CHAN-1:0]       chan_req,   // tapped channel req.
  input  logic [NB_IN_CHAN-1:0]       chan_gnt,   // tapped channel gnt.
  output logic                        mux_clear,  // one-cycle pulse.
  output logic [NB_IN_CHAN-1:0]       chan_en
);

  localparam int unsigned CNT_W = 16;  // counter width.

  logic [NB_IN_CHAN-1:0]            mask_q;   // enables, reset all ones.
  logic                             clear_q;  // clear pulse.
  logic [NB_IN_CHAN-1:0][CNT_W-1:0] cnt_q;    // grant counters.
  logic                             wr_ctrl;
  logic                             wr_mask;

  assign wr_ctrl = cfg_we && (cfg_addr == tcdm_pkg::CFG_CTRL);
  assign wr_mask = cfg_we && (cfg_addr == tcdm_pkg::CFG_MASK);

  // -------------------------------------------------
  // mask and clear
  // -------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
    if (!rst_ni) begin
      mask_q  <= '1;
      clear_q <= 1'b0;
    end else begin
      clear_q <= wr_ctrl & cfg_wdata[0];  // high the cycle after the write.
      if (wr_mask) begin
        mask_q <= cfg_wdata[NB_IN_CHAN-1:0];
      end
    end
  end

  // -------------------------------------------------
  // grant counters
  // -------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : grant_cnt
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      for (int unsigned j = 0; j < NB_IN_CHAN; j++) begin
        if (clear_q) begin
          cnt_q[j] <= '0;  // clear wins over a grant.
        end else if (chan_req[j] && chan_gnt[j] && (cnt_q[j] != '1)) begin
          cnt_q[j] <= cnt_q[j] + 1'b1;  // saturates at max.
        end
      end
    end
  end

  // read mux, unmapped addresses return zero.
  always_comb begin : read_decode
    cfg_rdata = '0;
    if (cfg_addr == tcdm_pkg::CFG_MASK) begin
      cfg_rdata[NB_IN_CHAN-1:0] = mask_q;
    end
    for (int unsigned j = 0; j < NB_IN_CHAN; j++) begin
      if (32'(cfg_addr) == 32'(tcdm_pkg::CFG_CNT_BASE) + j) begin
        cfg_rdata[CNT_W-1:0] = cnt_q[j];
      end
    end
  end

  assign mux_clear = clear_q;
  assign chan_en   = mask_q;

endmodule

`default_nettype wire

// ==== verilog/tcdm_core_mux.sv ====
// -------------------------------------------------
// round-robin funnel of input channels onto memory ports.
// channel j always lands on port j mod NB_OUT_CHAN.
// -------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tcdm_core_mux #(
  parameter int unsigned NB_IN_CHAN  = 4,
  parameter int unsigned NB_OUT_CHAN = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  clear,          // resets rr pointer.
  input  logic [NB_IN_CHAN-1:0]                 chan_en,        // per-channel enable.
  input  logic [NB_IN_CHAN-1:0]                 in_req,
  input  tcdm_pkg::tcdm_req_t [NB_IN_CHAN-1:0]  in_req_data,
  output logic [NB_IN_CHAN-1:0]                 in_gnt,
  output logic [NB_IN_CHAN-1:0]                 in_rsp_valid,
  output tcdm_pkg::tcdm_rsp_t [NB_IN_CHAN-1:0]  in_rsp,
  output logic [NB_OUT_CHAN-1:0]                mem_req,
  output tcdm_pkg::tcdm_req_t [NB_OUT_CHAN-1:0] mem_req_data,
  input  logic [NB_OUT_CHAN-1:0]                mem_gnt,
  input  logic [NB_OUT_CHAN-1:0]                mem_rsp_valid,
  input  tcdm_pkg::tcdm_rsp_t [NB_OUT_CHAN-1:0] mem_rsp
);

  // channels sharing one port, and the width of a slot index.
  localparam int unsigned NB_SLOT = NB_IN_CHAN / NB_OUT_CHAN;
  localparam int unsigned SW      = (NB_SLOT > 1) ? $clog2(NB_SLOT) : 1;

  logic [NB_IN_CHAN-1:0]           req_en;    // requests that may compete.
  logic [SW-1:0]                   rr_q;      // shared rotating start slot.
  logic [NB_OUT_CHAN-1:0][SW-1:0]  winner_d;  // slot picked this cycle.
  logic [NB_OUT_CHAN-1:0][SW-1:0]  winner_q;  // slot owning the response.
  logic [NB_OUT_CHAN-1:0]          found_d;   // port has a candidate.
  logic [NB_OUT_CHAN-1:0]          xfer_d;    // port transfers now.
  logic [NB_OUT_CHAN-1:0]          xfer_q;    // response due this cycle.

  assign req_en = in_req & chan_en;  // masked channels never compete.
  assign xfer_d = mem_req & mem_gnt;

  // -------------------------------------------------
  // round-robin pointer
  // -------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : rr_pointer
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (clear) begin
      rr_q <= '0;
    end else if (|xfer_d) begin  // moves once per busy cycle.
      if (rr_q == SW'(NB_SLOT - 1)) begin
        rr_q <= '0;  // wrap.
      end else begin
        rr_q <= rr_q + 1'b1;
      end
    end
  end

  // -------------------------------------------------
  // per-port rotating priority search
  // -------------------------------------------------
  always_comb begin : arbiter
    int unsigned slot;
    winner_d = '0;
    found_d  = '0;
    for (int unsigned i = 0; i < NB_OUT_CHAN; i++) begin
      for (int unsigned k = 0; k < NB_SLOT; k++) begin
        slot = 32'(rr_q) + k;  // start at pointer.
        if (slot >= NB_SLOT) begin
          slot = slot - NB_SLOT;  // modulo slot count.
        end
        if (!found_d[i] && req_en[slot*NB_OUT_CHAN+i]) begin
          found_d[i]  = 1'b1;  // first hit wins.
          winner_d[i] = SW'(slot);
        end
      end
    end
  end

  // forward the winning payload to each port.
  always_comb begin : fwd_req
    for (int unsigned i = 0; i < NB_OUT_CHAN; i++) begin
      mem_req[i]      = found_d[i];
      mem_req_data[i] = in_req_data[32'(winner_d[i])*NB_OUT_CHAN+i];
    end
  end

  // -------------------------------------------------
  // winner register, one per port
  // -------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : winner_reg
    if (!rst_ni) begin
      winner_q <= '0;
      xfer_q   <= '0;
    end else begin
      winner_q <= winner_d;  // who gets next cycle's response.
      xfer_q   <= xfer_d;    // one response per transfer.
    end
  end

  // -------------------------------------------------
  // grant and response steering
  // -------------------------------------------------
  always_comb begin : steer
    int unsigned ch;
    in_gnt       = '0;
    in_rsp_valid = '0;
    in_rsp       = '0;
    for (int unsigned i = 0; i < NB_OUT_CHAN; i++) begin
      for (int unsigned s = 0; s < NB_SLOT; s++) begin
        ch = s * NB_OUT_CHAN + i;  // channel in slot s of port i.
        // grant goes back in the request cycle.
        in_gnt[ch] = mem_gnt[i] & found_d[i] & (winner_d[i] == SW'(s));
        if (winner_q[i] == SW'(s)) begin
          in_rsp_valid[ch] = mem_rsp_valid[i] & xfer_q[i];
          in_rsp[ch]       = mem_rsp[i];  // data, opc and user together.
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tcdm_subsystem.sv ====
// -------------------------------------------------
// TCDM front end top: config block, core mux and one
// bank per mux port. channel counts and depth set here.
// -------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tcdm_subsystem #(
  parameter int unsigned NB_IN_CHAN  = 4,
  parameter int unsigned NB_OUT_CHAN = 2,    // must divide NB_IN_CHAN.
  parameter int unsigned BANK_WORDS  = 256
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // input channels.
  input  logic [NB_IN_CHAN-1:0]                in_req,
  input  tcdm_pkg::tcdm_req_t [NB_IN_CHAN-1:0] in_req_data,
  output logic [NB_IN_CHAN-1:0]                in_gnt,
  output logic [NB_IN_CHAN-1:0]                in_rsp_valid,
  output tcdm_pkg::tcdm_rsp_t [NB_IN_CHAN-1:0] in_rsp,
  // configuration port.
  input  logic                                 cfg_we,
  input  tcdm_pkg::cfg_addr_e                  cfg_addr,
  input  logic [tcdm_pkg::CFG_DW-1:0]          cfg_wdata,
  output logic [tcdm_pkg::CFG_DW-1:0]          cfg_rdata
);

  logic                                  mux_clear;      // rr and counter clear.
  logic [NB_IN_CHAN-1:0]                 chan_en;        // enable mask.
  logic [NB_OUT_CHAN-1:0]                mem_req;
  tcdm_pkg::tcdm_req_t [NB_OUT_CHAN-1:0] mem_req_data;
  logic [NB_OUT_CHAN-1:0]                mem_gnt;
  logic [NB_OUT_CHAN-1:0]                mem_rsp_valid;
  tcdm_pkg::tcdm_rsp_t [NB_OUT_CHAN-1:0] mem_rsp;

  tcdm_mux_ctrl #(
    .NB_IN_CHAN (NB_IN_CHAN)
  ) ctrl_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .chan_req  (in_req),     // counts req and gnt together.
    .chan_gnt  (in_gnt),
    .mux_clear (mux_clear),
    .chan_en   (chan_en)
  );

  tcdm_core_mux #(
    .NB_IN_CHAN  (NB_IN_CHAN),
    .NB_OUT_CHAN (NB_OUT_CHAN)
  ) mux_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear         (mux_clear),
    .chan_en       (chan_en),
    .in_req        (in_req),
    .in_req_data   (in_req_data),
    .in_gnt        (in_gnt),
    .in_rsp_valid  (in_rsp_valid),
    .in_rsp        (in_rsp),
    .mem_req       (mem_req),
    .mem_req_data  (mem_req_data),
    .mem_gnt       (mem_gnt),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp       (mem_rsp)
  );

  // one bank per port.
  for (genvar i = 0; i < NB_OUT_CHAN; i++) begin : gen_bank
    tcdm_bank #(
      .BANK_WORDS (BANK_WORDS)
    ) bank_i (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .req       (mem_req[i]),
      .req_data  (mem_req_data[i]),
      .gnt       (mem_gnt[i]),
      .rsp_valid (mem_rsp_valid[i]),
      .rsp       (mem_rsp[i])
    );
  end

endmodule

`default_nettype wire

// ==== tb/tcdm_subsystem_properties.sv ====
// -------------------------------------------------
// bound checks on the core mux: grant uniqueness,
// response timing, fairness and the enable mask.
// -------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tcdm_subsystem_properties #(
  parameter int unsigned NB_IN_CHAN  = 4,
  parameter int unsigned NB_OUT_CHAN = 2
) (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic [NB_IN_CHAN-1:0] chan_en,
  input logic [NB_IN_CHAN-1:0] in_req,
  input logic [NB_IN_CHAN-1:0] in_gnt,
  input logic [NB_IN_CHAN-1:0] in_rsp_valid
);

  localparam int unsigned NB_SLOT = NB_IN_CHAN / NB_OUT_CHAN;

  logic [NB_OUT_CHAN-1:0][NB_SLOT-1:0] port_gnt;  // grants regrouped by port.
  int unsigned                         wait_q [NB_IN_CHAN];  // ungranted cycles.

  always_comb begin : regroup
    for (int unsigned i = 0; i < NB_OUT_CHAN; i++) begin
      for (int unsigned s = 0; s < NB_SLOT; s++) begin
        port_gnt[i][s] = in_gnt[s*NB_OUT_CHAN+i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : wait_cnt
    if (!rst_ni) begin
      wait_q <= '{default: 0};
    end else begin
      for (int unsigned j = 0; j < NB_IN_CHAN; j++) begin
        if (in_req[j] && chan_en[j] && !in_gnt[j]) begin
          wait_q[j] <= wait_q[j] + 1;  // still losing.
        end else begin
          wait_q[j] <= 0;
        end
      end
    end
  end

  for (genvar i = 0; i < NB_OUT_CHAN; i++) begin : gen_port
    one_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(port_gnt[i]))
      else $error("port %0d granted more than one channel", i);
  end

  for (genvar j = 0; j < NB_IN_CHAN; j++) begin : gen_chan
    rsp_next: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (in_req[j] && in_gnt[j]) |=> in_rsp_valid[j])
      else $error("channel %0d missed its response", j);
    rsp_only: assert property (@(posedge clk_i) disable iff (!rst_ni)
      in_rsp_valid[j] |-> $past(in_req[j] && in_gnt[j]))
      else $error("channel %0d got a response with no transfer", j);
    fair: assert property (@(posedge clk_i) disable iff (!rst_ni) wait_q[j] < NB_SLOT)
      else $error("channel %0d starved past the round-robin bound", j);
    masked: assert property (@(posedge clk_i) disable iff (!rst_ni) !chan_en[j] |-> !in_gnt[j])
      else $error("channel %0d granted while disabled", j);
  end

endmodule

bind tcdm_core_mux tcdm_subsystem_properties #(
  .NB_IN_CHAN  (NB_IN_CHAN),
  .NB_OUT_CHAN (NB_OUT_CHAN)
) props_i (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .chan_en      (chan_en),
  .in_req       (in_req),
  .in_gnt       (in_gnt),
  .in_rsp_valid (in_rsp_valid)
);

`default_nettype wire

// ==== tb/tb_tcdm_subsystem.sv ====
// -------------------------------------------------
// testbench for the TCDM front end. applies a table of
// accesses and config operations against a bank model.
// -------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_tcdm_subsystem;

  localparam int unsigned NB_IN_CHAN  = 4;
  localparam int unsigned NB_OUT_CHAN = 2;
  localparam int unsigned BANK_WORDS  = 256;
  localparam int unsigned WAIT_LIM    = NB_IN_CHAN + 2;  // negedges per access entry.
  localparam tcdm_pkg::rsp_opc_e OK  = tcdm_pkg::OPC_OK;
  localparam tcdm_pkg::rsp_opc_e ERR = tcdm_pkg::OPC_ERR;

  typedef enum { KIND_ACC, KIND_CFG_WR, KIND_CFG_RD } kind_e;

  typedef struct {
    string                 name;
    kind_e                 kind;
    logic [NB_IN_CHAN-1:0] mask;    // requesting channels.
    logic [NB_IN_CHAN-1:0] stall;   // channels that must never be granted.
    logic                  wen;     // 1 = read.
    logic [15:0]           add;     // word or config address.
    logic                  spread;  // own region per channel.
    logic [31:0]           data;
    logic [3:0]            be;
    logic [3:0]            user;
    tcdm_pkg::rsp_opc_e    opc;     // expected status.
  } entry_t;

  logic                                  clk_i;
  logic                                  rst_ni;
  logic [NB_IN_CHAN-1:0]                 in_req;
  tcdm_pkg::tcdm_req_t [NB_IN_CHAN-1:0]  in_req_data;
  logic [NB_IN_CHAN-1:0]                 in_gnt;
  logic [NB_IN_CHAN-1:0]                 in_rsp_valid;
  tcdm_pkg::tcdm_rsp_t [NB_IN_CHAN-1:0]  in_rsp;
  logic                                  cfg_we;
  tcdm_pkg::cfg_addr_e                   cfg_addr;
  logic [tcdm_pkg::CFG_DW-1:0]           cfg_wdata;
  logic [tcdm_pkg::CFG_DW-1:0]           cfg_rdata;

  entry_t              tests [$];
  logic [31:0]         model_mem [NB_OUT_CHAN][BANK_WORDS];  // one array per bank.
  int unsigned         grants [NB_IN_CHAN];                  // transfers per channel.
  logic [NB_IN_CHAN-1:0] model_mask;
  tcdm_pkg::tcdm_rsp_t exp_rsp [NB_IN_CHAN];
  int                  errors;
  int                  failed;
  int                  cycles;
  int                  limit;

  tcdm_subsystem #(
    .NB_IN_CHAN  (NB_IN_CHAN),
    .NB_OUT_CHAN (NB_OUT_CHAN),
    .BANK_WORDS  (BANK_WORDS)
  ) tcdm_subsystem_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_req       (in_req),
    .in_req_data  (in_req_data),
    .in_gnt       (in_gnt),
    .in_rsp_valid (in_rsp_valid),
    .in_rsp       (in_rsp),
    .cfg_we       (cfg_we),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .cfg_rdata    (cfg_rdata)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;  // 40 ns period.
  end

  // -------------------------------------------------
  // table construction
  // -------------------------------------------------
  task automatic add_access(input string name, input logic [NB_IN_CHAN-1:0] mask,
      input logic [NB_IN_CHAN-1:0] stall, input logic wen, input logic [15:0] add,
      input logic spread, input logic [31:0] data, input logic [3:0] be,
      input logic [3:0] user, input tcdm_pkg::rsp_opc_e opc);
    entry_t e;
    e = '{name, KIND_ACC, mask, stall, wen, add, spread, data, be, user, opc};
    tests.push_back(e);
  endtask

  task automatic add_cfg(input string name, input kind_e kind, input logic [7:0] addr,
      input logic [31:0] data);
    entry_t e;
    e = '{name, kind, '0, '0, 1'b0, 16'(addr), 1'b0, data, 4'h0, 4'h0, OK};
    tests.push_back(e);
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    rnd = $urandom();
    add_access("wr_full_c0", 4'h1, 4'h0, 1'b0, 16'h0010, 1'b0, 32'h11223344, 4'hf, 4'h1, OK);
    add_access("wr_part_c0", 4'h1, 4'h0, 1'b0, 16'h0010, 1'b0, 32'haabbccdd, 4'h5, 4'h2, OK);
    add_access("rd_part_c0", 4'h1, 4'h0, 1'b1, 16'h0010, 1'b0, 32'h0, 4'h0, 4'h3, OK);
    add_access("wr_all", 4'hf, 4'h0, 1'b0, 16'h0040, 1'b1, rnd, 4'hf, 4'h4, OK);  // contention.
    add_access("rd_all", 4'hf, 4'h0, 1'b1, 16'h0040, 1'b1, 32'h0, 4'h0, 4'h5, OK);
    add_access("wr_c1", 4'h2, 4'h0, 1'b0, 16'h0005, 1'b0, 32'hcafe0001, 4'hf, 4'h6, OK);
    add_access("wr_oor_c1", 4'h2, 4'h0, 1'b0, 16'h0105, 1'b0, 32'hdead0000, 4'hf, 4'h7, ERR);
    add_access("rd_oor_c1", 4'h2, 4'h0, 1'b1, 16'h0105, 1'b0, 32'h0, 4'h0, 4'h8, ERR);
    add_access("rd_c1", 4'h2, 4'h0, 1'b1, 16'h0005, 1'b0, 32'h0, 4'h0, 4'h9, OK);
    add_cfg("mask_off_c1", KIND_CFG_WR, tcdm_pkg::CFG_MASK, 32'hd);
    add_cfg("mask_rd", KIND_CFG_RD, tcdm_pkg::CFG_MASK, 32'h0);
    add_access("stall_c1", 4'h3, 4'h2, 1'b1, 16'h0040, 1'b1, 32'h0, 4'h0, 4'ha, OK);
    add_cfg("mask_on", KIND_CFG_WR, tcdm_pkg::CFG_MASK, 32'hf);
    add_access("resume_c1", 4'h2, 4'h0, 1'b1, 16'h0040, 1'b1, 32'h0, 4'h0, 4'hb, OK);
    add_access("wr_other_c1", 4'h2, 4'h0, 1'b0, 16'h0080, 1'b0, ~rnd, 4'hf, 4'he, OK);
    add_access("wr_share_c0", 4'h1, 4'h0, 1'b0, 16'h0080, 1'b0, 32'h5a5a1234, 4'hf, 4'hc, OK);
    add_access("rd_share_c2", 4'h4, 4'h0, 1'b1, 16'h0080, 1'b0, 32'h0, 4'h0, 4'hd, OK);
    add_access("rd_other_c3", 4'h8, 4'h0, 1'b1, 16'h0080, 1'b0, 32'h0, 4'h0, 4'hf, OK);
    add_cfg("cfg_unmapped", KIND_CFG_RD, 8'h40, 32'h0);
    for (int j = 0; j < NB_IN_CHAN; j++) begin
      add_cfg($sformatf("cnt_c%0d", j), KIND_CFG_RD, 8'(int'(tcdm_pkg::CFG_CNT_BASE) + j), '0);
    end
    add_cfg("clear", KIND_CFG_WR, tcdm_pkg::CFG_CTRL, 32'h1);
    for (int j = 0; j < NB_IN_CHAN; j++) begin
      add_cfg($sformatf("cnt_clr_c%0d", j), KIND_CFG_RD,
        8'(int'(tcdm_pkg::CFG_CNT_BASE) + j), '0);
    end
  endtask

  // -------------------------------------------------
  // reference model
  // -------------------------------------------------
  function automatic tcdm_pkg::tcdm_req_t build_req(input entry_t e, input int ch);
    tcdm_pkg::tcdm_req_t r;
    r.add  = e.spread ? e.add + 16'(16 * ch) : e.add;  // 16 words per channel.
    r.wen  = e.wen;
    r.be   = e.be;
    r.data = e.spread ? e.data ^ (32'(ch) << 28) : e.data;
    r.user = e.user ^ 4'(ch);  // distinct tag per channel.
    return r;
  endfunction

  function automatic tcdm_pkg::tcdm_rsp_t model_access(input tcdm_pkg::tcdm_req_t r,
      input int ch, input tcdm_pkg::rsp_opc_e opc);
    tcdm_pkg::tcdm_rsp_t x;
    int bank;
    int a;
    bank     = ch % NB_OUT_CHAN;  // fixed channel to port map.
    a        = int'(r.add);
    x.r_data = '0;
    x.r_opc  = opc;
    x.r_user = r.user;
    if (a < BANK_WORDS) begin
      if (r.wen) begin
        x.r_data = model_mem[bank][a];
      end else begin
        for (int b = 0; b < 4; b++) begin
          if (r.be[b]) model_mem[bank][a][8*b +: 8] = r.data[8*b +: 8];  // byte merge.
        end
      end
    end
    return x;
  endfunction

  function automatic logic [31:0] cfg_expect(input int a);
    int base;
    base = int'(tcdm_pkg::CFG_CNT_BASE);
    if (a == int'(tcdm_pkg::CFG_MASK)) return 32'(model_mask);
    if (a >= base && a < base + NB_IN_CHAN) return 32'(grants[a - base]);
    return '0;  // ctrl and holes read zero.
  endfunction

  // -------------------------------------------------
  // compare tasks
  // -------------------------------------------------
  task automatic check_rsp(input string name, input tcdm_pkg::tcdm_rsp_t exp,
      input tcdm_pkg::tcdm_rsp_t act);
    if (act !== exp) begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_cfg(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  // -------------------------------------------------
  // entry runners
  // -------------------------------------------------
  task automatic run_access(input entry_t e);
    logic [NB_IN_CHAN-1:0] pending;
    logic [NB_IN_CHAN-1:0] rsp_wait;
    int unsigned           waited;
    for (int ch = 0; ch < NB_IN_CHAN; ch++) begin
      if (e.mask[ch] && !e.stall[ch]) begin
        grants[ch]++;  // one transfer per enabled requester.
      end
    end
    @(posedge clk_i);
    for (int ch = 0; ch < NB_IN_CHAN; ch++) begin
      in_req_data[ch] <= build_req(e, ch);
    end
    in_req   <= e.mask;
    pending  = e.mask;
    rsp_wait = '0;
    waited   = 0;
    while (waited < WAIT_LIM && (|pending || |rsp_wait)) begin
      @(negedge clk_i);  // outputs settled here.
      waited++;
      for (int ch = 0; ch < NB_IN_CHAN; ch++) begin
        if (rsp_wait[ch]) begin
          rsp_wait[ch] = 1'b0;
          if (!in_rsp_valid[ch]) begin
            $display("%s: no response on channel %0d one cycle after its grant", e.name, ch);
            errors++;
          end else begin
            check_rsp(e.name, exp_rsp[ch], in_rsp[ch]);
          end
        end
        if (pending[ch] && in_gnt[ch]) begin
          pending[ch]  = 1'b0;
          rsp_wait[ch] = 1'b1;
          exp_rsp[ch]  = model_access(build_req(e, ch), ch, e.opc);
          if (e.stall[ch]) begin
            $display("%s: channel %0d was granted while disabled", e.name, ch);
            errors++;
          end
        end
      end
      @(posedge clk_i);
      in_req <= pending;  // drop req once granted.
    end
    for (int ch = 0; ch < NB_IN_CHAN; ch++) begin
      if (pending[ch] && !e.stall[ch]) begin
        $display("%s: channel %0d was never granted", e.name, ch);
        errors++;
      end
      if (rsp_wait[ch]) begin
        $display("%s: response on channel %0d never checked", e.name, ch);
        errors++;
      end
    end
    in_req <= '0;  // disabled channels give up here.
  endtask

  task automatic run_cfg_write(input entry_t e);
    @(posedge clk_i);
    cfg_we    <= 1'b1;
    cfg_addr  <= tcdm_pkg::cfg_addr_e'(e.add[7:0]);
    cfg_wdata <= e.data;
    @(posedge clk_i);
    cfg_we <= 1'b0;
    if (e.add[7:0] == tcdm_pkg::CFG_MASK) model_mask = e.data[NB_IN_CHAN-1:0];
    if (e.add[7:0] == tcdm_pkg::CFG_CTRL && e.data[0]) grants = '{default: 0};
    repeat (2) @(posedge clk_i);  // clear pulse lands.
  endtask

  task automatic run_cfg_read(input entry_t e);
    @(posedge clk_i);
    cfg_addr <= tcdm_pkg::cfg_addr_e'(e.add[7:0]);
    @(negedge clk_i);
    check_cfg(e.name, cfg_expect(int'(e.add[7:0])), cfg_rdata);
  endtask

  // -------------------------------------------------
  // watchdog and main sequence
  // -------------------------------------------------
  initial begin : watchdog
    cycles = 0;
    while (limit == 0 || cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout after %0d cycles, the table did not complete", cycles);
    $display("Regression failed");
    $finish;
  end

  initial begin : main
    int errors_before;
    void'($urandom(84));
    limit       = 0;
    rst_ni      = 1'b0;
    in_req      = '0;
    in_req_data = '0;
    cfg_we      = 1'b0;
    cfg_addr    = tcdm_pkg::CFG_CTRL;
    cfg_wdata   = '0;
    model_mask  = '1;  // all channels enabled out of reset.
    grants      = '{default: 0};
    errors      = 0;
    failed      = 0;
    build_table();
    limit = tests.size() * int'(NB_IN_CHAN + 4) + 22;  // reset plus margin.
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    foreach (tests[t]) begin
      errors_before = errors;
      case (tests[t].kind)
        KIND_ACC:    run_access(tests[t]);
        KIND_CFG_WR: run_cfg_write(tests[t]);
        default:     run_cfg_read(tests[t]);
      endcase
      if (errors == errors_before) begin
        $display("%s: ok", tests[t].name);
      end else begin
        failed++;
        $display("%s: failed with %0d errors", tests[t].name, errors - errors_before);
      end
    end
    $display("tests %0d, failed %0d, errors %0d", tests.size(), failed, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tcdm_subsystem.f ====
verilog/tcdm_pkg.sv
verilog/tcdm_bank.sv
verilog/tcdm_mux_ctrl.sv
verilog/tcdm_core_mux.sv
verilog/tcdm_subsystem.sv
tb/tcdm_subsystem_properties.sv
tb/tb_tcdm_subsystem.sv

// ==== Makefile ====
# Verilator build and run of the TCDM front end testbench.
TOP = tb_tcdm_subsystem

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tcdm_subsystem.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
